// ==== sources.f ====
sub_pkg.sv
sub_operand_stage.sv
sub_block_lookahead.sv
sub_prefix_tree.sv
sub_sum_stage.sv
sub64_top.sv
tb_sub64.sv

// ==== sub64_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sub64_top
(
  input  logic           clk,
  input  logic           reset,
  input  sub_pkg::word_t x_a,
  input  sub_pkg::word_t x_b,
  output sub_pkg::word_t wx,
  output logic           cout
);

  import sub_pkg::*;

  operand_t              operands;
  bit_pg_t               pg;
  block_pg_t             blocks;
  logic [NUM_BLOCKS-1:0] block_carry;
  logic                  carry_out;
  result_t               result;

  assign operands.a = x_a;
  assign operands.b = x_b;

  sub_operand_stage u_operand_stage
  (
    .clk      (clk),
    .reset    (reset),
    .operands (operands),
    .pg       (pg)
  );

  //////////////////////////////////////////////////
  // One lookahead cell per 4-bit block
  //////////////////////////////////////////////////

  for (genvar blk = 0; blk < NUM_BLOCKS; blk++)
  begin : g_block
    sub_block_lookahead u_lookahead
    (
      .bit_p   (pg.p[blk*BLOCK_W +: BLOCK_W]),
      .bit_g   (pg.g[blk*BLOCK_W +: BLOCK_W]),
      .group_p (blocks.p[blk]),
      .group_g (blocks.g[blk])
    );
  end

  sub_prefix_tree u_prefix_tree
  (
    .blocks      (blocks),
    .block_carry (block_carry),
    .carry_out   (carry_out)
  );

  sub_sum_stage u_sum_stage
  (
    .clk         (clk),
    .reset       (reset),
    .pg          (pg),
    .block_carry (block_carry),
    .carry_out   (carry_out),
    .result      (result)
  );

  assign wx   = result.diff;
  assign cout = result.borrow;                        // Borrow flag

endmodule

`default_nettype wire

// ==== sub_block_lookahead.sv ====
`timescale 1ns/1ps
`default_nettype none

module sub_block_lookahead
(
  input  logic [sub_pkg::BLOCK_W-1:0] bit_p,
  input  logic [sub_pkg::BLOCK_W-1:0] bit_g,
  output logic                        group_p,
  output logic                        group_g
);

  import sub_pkg::*;

  // Whole block passes a carry only if every bit does
  assign group_p = &bit_p;

  //////////////////////////////////////////////////
  // Group generate as a flat lookahead sum
  //////////////////////////////////////////////////

  always_comb
  begin
    logic term;

    group_g = 1'b0;
    for (int i = 0; i < BLOCK_W; i++)
    begin
      term = bit_g[i];                                // Carry born at bit i
      for (int j = i + 1; j < BLOCK_W; j++)
      begin
        term = term & bit_p[j];                       // Must survive bits above
      end
      group_g = group_g | term;
    end
  end

endmodule

`default_nettype wire

// ==== sub_operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module sub_operand_stage
(
  input  logic              clk,
  input  logic              reset,
  input  sub_pkg::operand_t operands,
  output sub_pkg::bit_pg_t  pg
);

  import sub_pkg::*;

  operand_t operands_q;                               // Entry register
  word_t    b_inv;

  //////////////////////////////////////////////////
  // Operand register
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      operands_q <= '0;
    end
    else
    begin
      operands_q <= operands;                         // New pair every cycle
    end
  end

  //////////////////////////////////////////////////
  // Bit propagate and generate
  //////////////////////////////////////////////////

  // Subtraction as addition of the inverted subtrahend
  assign b_inv = ~operands_q.b;

  assign pg.p = operands_q.a ^ b_inv;                 // Half sum
  assign pg.g = operands_q.a & b_inv;                 // Both ones

  // Unknown operands would poison every later stage
  a_operands_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(operands_q)
  )
  else
    $error("registered operands carry unknown bits");

endmodule

`default_nettype wire

// ==== sub_pkg.sv ====
`default_nettype none

package sub_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  localparam int WORD_W        = 64;                  // Operand width
  localparam int BLOCK_W       = 4;                   // Bits per lookahead block
  localparam int NUM_BLOCKS    = WORD_W / BLOCK_W;    // 16 blocks
  localparam int PREFIX_LEVELS = $clog2(NUM_BLOCKS);  // Kogge-Stone depth

  // a - b is done as a + ~b + 1
  localparam logic SUB_CARRY_IN = 1'b1;

  //////////////////////////////////////////////////
  // Datapath types
  //////////////////////////////////////////////////

  typedef logic [WORD_W-1:0] word_t;

  typedef struct packed {
    word_t a;                                         // Minuend
    word_t b;                                         // Subtrahend
  } operand_t;

  // Bit level terms of a plus inverted b
  typedef struct packed {
    word_t p;                                         // Propagate
    word_t g;                                         // Generate
  } bit_pg_t;

  typedef struct packed {
    logic [NUM_BLOCKS-1:0] p;                         // One per block
    logic [NUM_BLOCKS-1:0] g;
  } block_pg_t;

  typedef struct packed {
    word_t diff;                                      // a - b mod 2^64
    logic  borrow;                                    // Set when a < b unsigned
  } result_t;

endpackage

`default_nettype wire

// ==== sub_prefix_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module sub_prefix_tree
(
  input  sub_pkg::block_pg_t              blocks,
  output logic [sub_pkg::NUM_BLOCKS-1:0] block_carry,
  output logic                           carry_out
);

  import sub_pkg::*;

  // Level 0 holds the block terms, level PREFIX_LEVELS the full prefixes
  logic [NUM_BLOCKS-1:0] lvl_p [PREFIX_LEVELS+1];
  logic [NUM_BLOCKS-1:0] lvl_g [PREFIX_LEVELS+1];
  logic [NUM_BLOCKS-1:0] prefix_c;                    // Carry out of block i

  //////////////////////////////////////////////////
  // Kogge-Stone network over the blocks
  //////////////////////////////////////////////////

  always_comb
  begin
    lvl_p[0] = blocks.p;
    lvl_g[0] = blocks.g;

    for (int l = 1; l <= PREFIX_LEVELS; l++)
    begin
      for (int i = 0; i < NUM_BLOCKS; i++)
      begin
        if (i >= (1 << (l - 1)))
        begin
          // Merge with the span that ends 2^(l-1) blocks lower
          lvl_g[l][i] = lvl_g[l-1][i] |
                        (lvl_p[l-1][i] & lvl_g[l-1][i - (1 << (l - 1))]);
          lvl_p[l][i] = lvl_p[l-1][i] & lvl_p[l-1][i - (1 << (l - 1))];
        end
        else
        begin
          lvl_g[l][i] = lvl_g[l-1][i];                // Span already reaches bit 0
          lvl_p[l][i] = lvl_p[l-1][i];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Fold in the carry-in
  //////////////////////////////////////////////////

  assign prefix_c = lvl_g[PREFIX_LEVELS] |
                    (lvl_p[PREFIX_LEVELS] & {NUM_BLOCKS{SUB_CARRY_IN}});

  // Block 0 sees the +1 directly, block i the carry out of block i-1
  assign block_carry = {prefix_c[NUM_BLOCKS-2:0], SUB_CARRY_IN};
  assign carry_out   = prefix_c[NUM_BLOCKS-1];

endmodule

`default_nettype wire

// ==== sub_sum_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module sub_sum_stage
(
  input  logic                           clk,
  input  logic                           reset,
  input  sub_pkg::bit_pg_t               pg,
  input  logic [sub_pkg::NUM_BLOCKS-1:0] block_carry,
  input  logic                           carry_out,
  output sub_pkg::result_t               result
);

  import sub_pkg::*;

  word_t                 bit_carry;                   // Carry into each bit
  logic [NUM_BLOCKS-1:0] ripple_c;                    // Carry out of each block ripple
  result_t               result_d;

  //////////////////////////////////////////////////
  // Short ripple inside each block
  //////////////////////////////////////////////////

  always_comb
  begin
    logic carry;

    bit_carry = '0;
    ripple_c  = '0;
    for (int blk = 0; blk < NUM_BLOCKS; blk++)
    begin
      carry = block_carry[blk];                       // From the prefix tree
      for (int k = 0; k < BLOCK_W; k++)
      begin
        bit_carry[blk*BLOCK_W + k] = carry;
        carry = pg.g[blk*BLOCK_W + k] |
                (pg.p[blk*BLOCK_W + k] & carry);
      end
      ripple_c[blk] = carry;
    end
  end

  // No carry out of bit 63 means a < b
  assign result_d.diff   = pg.p ^ bit_carry;
  assign result_d.borrow = ~carry_out;

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result <= '0;
    end
    else
    begin
      result <= result_d;                             // Overwritten every cycle
    end
  end

  // Each block ripple lands on the carry the prefix tree gives the next block
  a_carry_chain: assert property (
    @(posedge clk) disable iff (reset)
    ripple_c == {carry_out, block_carry[NUM_BLOCKS-1:1]}
  )
  else
    $error("block ripple disagrees with prefix tree carries");

endmodule

`default_nettype wire

// ==== tb_sub64.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sub64;

  import sub_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 50;                   // Cycles before a wait gives up
  localparam int RANDOM_PAIRS = 200;
  localparam int EQUAL_PAIRS  = 50;

  logic    clk;
  logic    reset;
  word_t   x_a;
  word_t   x_b;
  word_t   wx;
  logic    cout;

  integer  seed;
  int      error_count;
  result_t exp_q[$];                                  // Expected results, oldest first
  bit      live_q[$];                                 // Clear for idle slots

  sub64_top dut0
  (
    .clk   (clk),
    .reset (reset),
    .x_a   (x_a),
    .x_b   (x_b),
    .wx    (wx),
    .cout  (cout)
  );

  always #2 clk = ~clk;                               // 4 ns period

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  function automatic result_t model(input word_t a, input word_t b);
    result_t r;
    r.diff   = a - b;                                 // Wraps mod 2^64
    r.borrow = (a < b);                               // Unsigned compare
    return r;
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = {$random(seed), $random(seed)};
    return w;
  endfunction

  function automatic int pending_checks();
    int n;
    n = 0;
    foreach (live_q[i])
    begin
      n += int'(live_q[i]);
    end
    return n;
  endfunction

  task automatic fail_stop();
    error_count++;
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected)
    begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      fail_stop();
    end
  endtask

  task automatic check_borrow(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      fail_stop();
    end
  endtask

  // Drive one pair, then check whatever the DUT shows for the pair two edges back
  task automatic run_cycle(input bit live, input word_t a, input word_t b);
    result_t expected;
    bit      check_now;
    @(posedge clk);
    x_a <= a;
    x_b <= b;
    exp_q.push_back(model(a, b));
    live_q.push_back(live);
    @(negedge clk);
    if (exp_q.size() > 2)
    begin
      expected  = exp_q.pop_front();
      check_now = live_q.pop_front();
      if (check_now)
      begin
        check_word(wx, expected.diff, "wx");
        check_borrow(cout, expected.borrow, "cout");
      end
    end
  endtask

  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    while (pending_checks() > 0)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("Timed out while draining the pipeline");
        fail_stop();
      end
      run_cycle(1'b0, '0, '0);
      cycles++;
    end
  endtask

  task automatic wait_reset_low();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (reset !== 1'b0)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("Timed out waiting for reset to be released");
        fail_stop();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_state();
    check_word(wx, '0, "wx after reset");
    check_borrow(cout, 1'b0, "cout after reset");
  endtask

  task automatic test_corners();
    run_cycle(1'b1, 64'h0, 64'h0);
    run_cycle(1'b1, 64'h0, 64'h1);                    // All ones with borrow
    run_cycle(1'b1, '1, '1);
    run_cycle(1'b1, 64'h8000_0000_0000_0000, 64'h1);
    run_cycle(1'b1, 64'h1, 64'h8000_0000_0000_0000);
    // Borrow runs from bit 0 up into the top block
    run_cycle(1'b1, 64'h1000_0000_0000_0000, 64'h1);
    drain_pipeline();
  endtask

  task automatic test_random_stream();
    for (int i = 0; i < RANDOM_PAIRS; i++)
    begin
      run_cycle(1'b1, rand_word(), rand_word());      // Back to back
    end
    drain_pipeline();
  endtask

  task automatic test_equal_operands();
    word_t v;
    for (int i = 0; i < EQUAL_PAIRS; i++)
    begin
      v = rand_word();
      run_cycle(1'b1, v, v);
    end
    drain_pipeline();
  endtask

  task automatic test_reset_midstream();
    for (int i = 0; i < 20; i++)
    begin
      run_cycle(1'b1, rand_word(), rand_word());
    end
    @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);                                   // Result register clears here
    @(negedge clk);
    check_word(wx, '0, "wx after mid-stream reset");
    check_borrow(cout, 1'b0, "cout after mid-stream reset");
    exp_q.delete();                                   // Pairs in flight are lost
    live_q.delete();
    @(posedge clk);
    reset <= 1'b0;
    wait_reset_low();
    for (int i = 0; i < 20; i++)
    begin
      run_cycle(1'b1, rand_word(), rand_word());
    end
    drain_pipeline();
  endtask

  initial
  begin
    clk         = 1'b0;
    reset       = 1'b1;
    x_a         = '0;
    x_b         = '0;
    seed        = 55316;
    error_count = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    wait_reset_low();

    test_reset_state();
    test_corners();
    test_random_stream();
    test_equal_operands();
    test_reset_midstream();

    if (error_count == 0)
    begin
      $display("Test passed");
      $finish;
    end
    else
    begin
      fail_stop();
    end
  end

endmodule

`default_nettype wire
